// ==== filelist.f ====
logic/game_pkg.sv
logic/display_pkg.sv
logic/play_if.sv
logic/game_timer.sv
logic/player_mover.sv
logic/bee_swarm.sv
logic/life_keeper.sv
logic/score_keeper.sv
logic/hex_panel.sv
logic/bounce_top.sv
sim/bounce_assertions.sv
sim/bounce_tb.sv

// ==== Bender.yml ====
package:
  name: bounce

sources:
  - files:
      - logic/game_pkg.sv
      - logic/display_pkg.sv
      - logic/play_if.sv
      - logic/game_timer.sv
      - logic/player_mover.sv
      - logic/bee_swarm.sv
      - logic/life_keeper.sv
      - logic/score_keeper.sv
      - logic/hex_panel.sv
      - logic/bounce_top.sv
  - target: simulation
    files:
      - sim/bounce_assertions.sv
      - sim/bounce_tb.sv

// ==== sim/bounce_tb.sv ====
// Testbench for the bee-dodging game, runs the play phases on the top level and checks its outputs
module bounce_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SLOW  = 8;
    localparam int MID   = 6;
    localparam int FAST  = 4;
    localparam int SCORE = 64;

    // Cycle budgets, sized for the slowest speed
    localparam int WALL_LIMIT  = (game_pkg::X_MAX - game_pkg::HOME_X + 3) * SLOW;
    localparam int BEE_TICKS   = 40;
    localparam int BEE_LIMIT   = (BEE_TICKS + 1) * SLOW;
    localparam int CLEAR_LIMIT = 1;
    localparam int PHASE_SUM   = 8 + 3 * WALL_LIMIT + 2 * (CLEAR_LIMIT + 1) + 2 * BEE_LIMIT;
    localparam int TIMEOUT     = 2 * PHASE_SUM;

    logic        CLOCK_50;
    logic        rst_n;
    logic [3:0]  KEY;
    logic [17:0] SW;
    logic [17:0] LEDR;
    logic [6:0]  HEX0;
    logic [6:0]  HEX1;
    logic [6:0]  HEX2;
    logic [6:0]  HEX3;
    logic [6:0]  HEX4;
    logic [6:0]  HEX5;
    logic [6:0]  HEX6;
    logic [6:0]  HEX7;

    int         errors = 0;
    int         cycle_count = 0;
    logic [6:0] score_lo_seen;
    logic [6:0] score_hi_seen;

    bounce_top #(
        .NUM_BEES         (6),
        .MOVE_PERIOD_SLOW (SLOW),
        .MOVE_PERIOD_MID  (MID),
        .MOVE_PERIOD_FAST (FAST),
        .SCORE_PERIOD     (SCORE)
    ) UUT (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .KEY      (KEY),
        .SW       (SW),
        .LEDR     (LEDR),
        .HEX0     (HEX0),
        .HEX1     (HEX1),
        .HEX2     (HEX2),
        .HEX3     (HEX3),
        .HEX4     (HEX4),
        .HEX5     (HEX5),
        .HEX6     (HEX6),
        .HEX7     (HEX7)
    );

    initial CLOCK_50 = 1'b0;

    always #50 CLOCK_50 = ~CLOCK_50;

    // Last score digits shown while the game was running
    always @(posedge CLOCK_50)
    begin
        if (rst_n && !LEDR[15])
        begin
            score_lo_seen <= HEX4;
            score_hi_seen <= HEX5;
        end
    end

    always @(posedge CLOCK_50)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT)
        begin
            $display("Timeout: the phases did not finish within %0d cycles", TIMEOUT);
            errors++;
            finish_run();
        end
    end

    task automatic finish_run();
        int assert_fails;
        assert_fails = UUT.u_checks.fail_count;
        $display("Port check errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    // Drive point is 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLOCK_50);
        #10;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) next_cycle();
        rst_n = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [6:0] got,
                               input logic [6:0] expected);
        if (got !== expected)
        begin
            errors++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, got);
        end
    endtask

    task automatic check_text();
        logic [6:0] digits [8];
        digits = '{HEX0, HEX1, HEX2, HEX3, HEX4, HEX5, HEX6, HEX7};
        for (int i = 0; i < 8; i++)
            check_value($sformatf("HEX%0d", i), digits[i], display_pkg::OVER_TEXT[i]);
    endtask

    task automatic wait_hex0(input logic [6:0] expected, input int budget, input string what);
        int n;
        n = 0;
        while (HEX0 !== expected && n < budget)
        begin
            next_cycle();
            n++;
        end
        if (HEX0 !== expected)
        begin
            errors++;
            $display("%s did not show on HEX0 within %0d cycles", what, budget);
        end
    endtask

    task automatic wait_led(input logic level, input int budget, input string what);
        int n;
        n = 0;
        while (LEDR[15] !== level && n < budget)
        begin
            next_cycle();
            n++;
        end
        if (LEDR[15] !== level)
        begin
            errors++;
            $display("%s did not happen within %0d cycles", what, budget);
        end
    endtask

    // One switch on is the middle speed, both on the fast one
    task automatic pick_speed(output int period);
        logic [1:0] sel;
        sel = 2'($urandom % 4);
        SW[17:16] = sel;
        case (sel)
            2'b00:   period = SLOW;
            2'b11:   period = FAST;
            default: period = MID;
        endcase
    endtask

    task automatic pulse_clear();
        SW[15] = 1'b1;
        next_cycle();
        SW[15] = 1'b0;
        wait_led(1'b0, CLEAR_LIMIT, "Restart after the clear switch fell");
    endtask

    initial
    begin
        int period;
        int bee_budget;
        void'($urandom(32'hb81f));
        KEY = 4'hF;
        SW  = '0;
        apply_reset();

        check_value("HEX0", HEX0, display_pkg::HEX_GLYPH[3]);
        check_value("HEX4", HEX4, display_pkg::HEX_GLYPH[0]);
        check_value("HEX5", HEX5, display_pkg::HEX_GLYPH[0]);
        check_value("HEX6", HEX6, display_pkg::HEX_GLYPH[0]);
        check_value("HEX7", HEX7, display_pkg::HEX_GLYPH[0]);
        check_value("LEDR[15]", {6'd0, LEDR[15]}, 7'd0);

        // Right key into the wall with all bees off
        pick_speed(period);
        KEY = 4'b1110;
        wait_hex0(display_pkg::HEX_GLYPH[2], WALL_LIMIT, "First wall contact");
        wait_hex0(display_pkg::HEX_GLYPH[1], WALL_LIMIT, "Second wall contact");
        pick_speed(period);
        wait_led(1'b1, WALL_LIMIT, "Game over after the third wall contact");
        KEY = 4'hF;
        check_text();

        pulse_clear();
        check_value("HEX0", HEX0, display_pkg::HEX_GLYPH[3]);
        check_value("HEX1", HEX1, display_pkg::SEG_BLANK);
        check_value("HEX2", HEX2, display_pkg::SEG_BLANK);
        check_value("HEX3", HEX3, display_pkg::SEG_BLANK);

        // Bee 0 restarts from (50, 30) and comes within reach of home after 27 moves
        SW[0] = 1'b1;
        pick_speed(period);
        apply_reset();
        bee_budget = SLOW + 1 + (BEE_TICKS - 1) * period;
        wait_hex0(display_pkg::HEX_GLYPH[2], bee_budget, "Life lost to bee 0");
        wait_led(1'b1, BEE_LIMIT, "Game over from bee 0");
        pulse_clear();
        check_value("HEX4", HEX4, display_pkg::HEX_GLYPH[0]);
        check_value("HEX5", HEX5, display_pkg::HEX_GLYPH[0]);
        check_value("HEX6", HEX6, score_lo_seen);
        check_value("HEX7", HEX7, score_hi_seen);
        finish_run();
    end

endmodule

// ==== sim/bounce_assertions.sv ====
// Concurrent checks on the game outputs and counters, attached to the top level with bind
module bounce_assertions (
    input logic              CLOCK_50,
    input logic              rst_n,
    input logic [17:0]       LEDR,
    input logic [6:0]        HEX0,
    input logic [6:0]        HEX1,
    input logic [6:0]        HEX2,
    input logic [6:0]        HEX3,
    input logic [6:0]        HEX4,
    input logic [6:0]        HEX5,
    input logic [6:0]        HEX6,
    input logic [6:0]        HEX7,
    input logic              game_over,
    input game_pkg::lives_t  lives,
    input game_pkg::score_t  score,
    input game_pkg::score_t  high_score
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Only LEDR[15] is used
    led_map: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        (LEDR[17:16] == 2'b00) && (LEDR[14:0] == '0))
    else
    begin
        $error("Unused LEDR bits are not low");
        fail_count++;
    end

    // The game ends only when the last life is lost
    over_last_life: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        $rose(LEDR[15]) |-> ($past(lives) == 2'd1))
    else
    begin
        $error("Game over lit without the last life being lost");
        fail_count++;
    end

    over_text: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        game_over |-> ({HEX7, HEX6, HEX5, HEX4} == {display_pkg::OVER_TEXT[7],
        display_pkg::OVER_TEXT[6], display_pkg::OVER_TEXT[5], display_pkg::OVER_TEXT[4]}) &&
        ({HEX3, HEX2, HEX1, HEX0} == {display_pkg::OVER_TEXT[3], display_pkg::OVER_TEXT[2],
        display_pkg::OVER_TEXT[1], display_pkg::OVER_TEXT[0]}))
    else
    begin
        $error("Digits do not show the game-over text");
        fail_count++;
    end

    // Lives only drop by one or reload when the game ends
    lives_step: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        $changed(lives) |-> (lives == $past(lives) - 2'd1) || (lives == game_pkg::LIVES_FULL))
    else
    begin
        $error("Lives changed by more than one step");
        fail_count++;
    end

    score_clear: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        $rose(game_over) |-> ##[0:1] (score == '0))
    else
    begin
        $error("Score not cleared at game over");
        fail_count++;
    end

    score_step: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        $changed(score) |-> (score == game_pkg::score_t'($past(score) + 1'b1)) ||
        (game_over && score == '0))
    else
    begin
        $error("Score did not count up by one");
        fail_count++;
    end

    // High score never drops, game over included
    high_keep: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        (high_score >= score) && (high_score >= $past(high_score)))
    else
    begin
        $error("High score fell below score or its earlier value");
        fail_count++;
    end

endmodule

bind bounce_top bounce_assertions u_checks (.*);

// ==== logic/bounce_top.sv ====
// Top level of the bee-dodging game with board-style switches, keys, LEDs and digits
module bounce_top #(
    parameter int          NUM_BEES         = 6,
    parameter int unsigned MOVE_PERIOD_SLOW = 1000000,
    parameter int unsigned MOVE_PERIOD_MID  = 750000,
    parameter int unsigned MOVE_PERIOD_FAST = 500000,
    parameter int unsigned SCORE_PERIOD     = 100000000
) (
    input  logic        CLOCK_50,
    input  logic        rst_n,
    input  logic [3:0]  KEY,
    input  logic [17:0] SW,
    output logic [17:0] LEDR,
    output logic [6:0]  HEX0,
    output logic [6:0]  HEX1,
    output logic [6:0]  HEX2,
    output logic [6:0]  HEX3,
    output logic [6:0]  HEX4,
    output logic [6:0]  HEX5,
    output logic [6:0]  HEX6,
    output logic [6:0]  HEX7
);

    logic                  move_tick;
    logic                  score_tick;
    logic                  game_over;
    logic [NUM_BEES-1:0]   bee_enable;
    game_pkg::lives_t      lives;
    game_pkg::score_t      score;
    game_pkg::score_t      high_score;

    play_if play ();

    assign bee_enable = SW[NUM_BEES-1:0];
    // Only the restart hint LED is used
    assign LEDR = {2'b00, game_over, 15'd0};

    game_timer #(
        .MOVE_PERIOD_SLOW (MOVE_PERIOD_SLOW),
        .MOVE_PERIOD_MID  (MOVE_PERIOD_MID),
        .MOVE_PERIOD_FAST (MOVE_PERIOD_FAST),
        .SCORE_PERIOD     (SCORE_PERIOD)
    ) u_timer (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .speed_sel  (SW[17:16]),
        .move_tick  (move_tick),
        .score_tick (score_tick)
    );

    player_mover u_player (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .keys      (KEY),
        .move_tick (move_tick),
        .game_over (game_over),
        .play      (play)
    );

    bee_swarm #(.NUM_BEES(NUM_BEES)) u_bees (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .move_tick  (move_tick),
        .bee_enable (bee_enable),
        .play       (play)
    );

    life_keeper u_lives (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .move_tick (move_tick),
        .clear_sw  (SW[15]),
        .play      (play),
        .lives     (lives),
        .game_over (game_over)
    );

    score_keeper #(.NUM_BEES(NUM_BEES)) u_score (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .score_tick (score_tick),
        .game_over  (game_over),
        .bee_enable (bee_enable),
        .score      (score),
        .high_score (high_score)
    );

    hex_panel u_hex (
        .lives      (lives),
        .score      (score),
        .high_score (high_score),
        .game_over  (game_over),
        .hex0       (HEX0),
        .hex1       (HEX1),
        .hex2       (HEX2),
        .hex3       (HEX3),
        .hex4       (HEX4),
        .hex5       (HEX5),
        .hex6       (HEX6),
        .hex7       (HEX7)
    );

endmodule

// ==== logic/hex_panel.sv ====
// Seven-segment decoding of lives and scores, replaced by fixed text during game over
module hex_panel (
    input  logic [1:0]        lives,
    input  logic [7:0]        score,
    input  logic [7:0]        high_score,
    input  logic              game_over,
    output display_pkg::seg_t hex0,
    output display_pkg::seg_t hex1,
    output display_pkg::seg_t hex2,
    output display_pkg::seg_t hex3,
    output display_pkg::seg_t hex4,
    output display_pkg::seg_t hex5,
    output display_pkg::seg_t hex6,
    output display_pkg::seg_t hex7
);

    assign hex0 = game_over ? display_pkg::OVER_TEXT[0] : display_pkg::HEX_GLYPH[{2'b00, lives}];
    // Middle digits only light up for the text
    assign hex1 = game_over ? display_pkg::OVER_TEXT[1] : display_pkg::SEG_BLANK;
    assign hex2 = game_over ? display_pkg::OVER_TEXT[2] : display_pkg::SEG_BLANK;
    assign hex3 = game_over ? display_pkg::OVER_TEXT[3] : display_pkg::SEG_BLANK;

    // Score on HEX5:HEX4, high score on HEX7:HEX6
    assign hex4 = game_over ? display_pkg::OVER_TEXT[4] : display_pkg::HEX_GLYPH[score[3:0]];
    assign hex5 = game_over ? display_pkg::OVER_TEXT[5] : display_pkg::HEX_GLYPH[score[7:4]];
    assign hex6 = game_over ? display_pkg::OVER_TEXT[6] : display_pkg::HEX_GLYPH[high_score[3:0]];
    assign hex7 = game_over ? display_pkg::OVER_TEXT[7] : display_pkg::HEX_GLYPH[high_score[7:4]];

endmodule

// ==== logic/score_keeper.sv ====
// Score counter that runs while bees are active, plus the high score
module score_keeper #(
    parameter int NUM_BEES = 6
) (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic                score_tick,
    input  logic                game_over,
    input  logic [NUM_BEES-1:0] bee_enable,
    output game_pkg::score_t    score,
    output game_pkg::score_t    high_score
);

    game_pkg::score_t score_next;

    always_comb
    begin
        score_next = score;
        if (game_over)
            score_next = '0;
        else if (score_tick && (|bee_enable))
            score_next = score + 1'b1;
    end

    // High score updates together with score, so it never trails
    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            score      <= '0;
            high_score <= '0;
        end
        else
        begin
            score <= score_next;
            if (score_next > high_score)
                high_score <= score_next;
        end
    end

endmodule

// ==== logic/life_keeper.sv ====
// Lives counter with respawn strobe and game-over latch cleared by a switch pulse
module life_keeper (
    input  logic                 CLOCK_50,
    input  logic                 rst_n,
    input  logic                 move_tick,
    input  logic                 clear_sw,
    play_if.keeper               play,
    output game_pkg::lives_t     lives,
    output logic                 game_over
);

    logic clear_armed;
    logic hit;

    assign hit = play.wall_hit || play.bee_hit;

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lives        <= game_pkg::LIVES_FULL;
            game_over    <= 1'b0;
            play.respawn <= 1'b0;
            clear_armed  <= 1'b0;
        end
        else
        begin
            play.respawn <= 1'b0;
            // The respawn check keeps one contact from costing two lives
            if (move_tick && hit && !game_over && !play.respawn)
            begin
                play.respawn <= 1'b1;
                if (lives > 2'd1)
                    lives <= lives - 1'b1;
                else
                begin
                    game_over   <= 1'b1;
                    lives       <= game_pkg::LIVES_FULL;
                    clear_armed <= 1'b0;
                end
            end
            else if (game_over)
            begin
                // Switch must go high, then low, to restart
                if (clear_sw)
                    clear_armed <= 1'b1;
                else if (clear_armed)
                begin
                    game_over   <= 1'b0;
                    clear_armed <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== logic/bee_swarm.sv ====
// Diagonally moving bees that bounce off the walls, with the proximity check against the player
module bee_swarm #(
    parameter int NUM_BEES = 6
) (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic                move_tick,
    input  logic [NUM_BEES-1:0] bee_enable,
    play_if.swarm               play
);

    game_pkg::coord_x_t bee_x    [NUM_BEES];
    game_pkg::coord_y_t bee_y    [NUM_BEES];
    game_pkg::bee_dir_t bee_dir  [NUM_BEES];
    game_pkg::bee_dir_t dir_next [NUM_BEES];
    logic               hit_any;

    // A bee sitting on a wall turns around in the same step
    always_comb
    begin
        for (int i = 0; i < NUM_BEES; i++)
        begin
            dir_next[i] = bee_dir[i];
            if (bee_x[i] >= game_pkg::X_MAX)
                dir_next[i].x_neg = 1'b1;
            else if (bee_x[i] <= game_pkg::X_MIN)
                dir_next[i].x_neg = 1'b0;
            if (bee_y[i] >= game_pkg::Y_MAX)
                dir_next[i].y_neg = 1'b1;
            else if (bee_y[i] <= game_pkg::Y_MIN)
                dir_next[i].y_neg = 1'b0;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_BEES; i++)
            begin
                bee_x[i]   <= game_pkg::BEE_START[i].x;
                bee_y[i]   <= game_pkg::BEE_START[i].y;
                bee_dir[i] <= game_pkg::BEE_START[i].dir;
            end
        end
        else if (move_tick)
        begin
            for (int i = 0; i < NUM_BEES; i++)
            begin
                bee_dir[i] <= dir_next[i];
                bee_x[i]   <= dir_next[i].x_neg ? bee_x[i] - 1'b1 : bee_x[i] + 1'b1;
                bee_y[i]   <= dir_next[i].y_neg ? bee_y[i] - 1'b1 : bee_y[i] + 1'b1;
            end
        end
    end

    // Extended by one bit so the radius never wraps at the field edges
    always_comb
    begin
        logic near_x;
        logic near_y;
        hit_any = 1'b0;
        for (int i = 0; i < NUM_BEES; i++)
        begin
            near_x = ({1'b0, play.player_x} + 9'(game_pkg::HIT_RADIUS) >= {1'b0, bee_x[i]}) &&
                     ({1'b0, bee_x[i]} + 9'(game_pkg::HIT_RADIUS) >= {1'b0, play.player_x});
            near_y = ({1'b0, play.player_y} + 8'(game_pkg::HIT_RADIUS) >= {1'b0, bee_y[i]}) &&
                     ({1'b0, bee_y[i]} + 8'(game_pkg::HIT_RADIUS) >= {1'b0, play.player_y});
            if (bee_enable[i] && near_x && near_y)
                hit_any = 1'b1;
        end
    end

    assign play.bee_hit = hit_any;

endmodule

// ==== logic/player_mover.sv ====
// Player position register steered by the keys, with wall detection and return to home
module player_mover (
    input  logic       CLOCK_50,
    input  logic       rst_n,
    input  logic [3:0] keys,
    input  logic       move_tick,
    input  logic       game_over,
    play_if.mover      play
);

    logic [3:0] pressed;

    // Keys are active low
    assign pressed = ~keys;

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            play.player_x <= game_pkg::HOME_X;
            play.player_y <= game_pkg::HOME_Y;
        end
        else if (play.respawn)
        begin
            play.player_x <= game_pkg::HOME_X;
            play.player_y <= game_pkg::HOME_Y;
        end
        else if (move_tick && !game_over)
        begin
            // Opposite keys held together cancel out
            if (pressed[0] && !pressed[3])
                play.player_x <= play.player_x + 1'b1;
            else if (pressed[3] && !pressed[0])
                play.player_x <= play.player_x - 1'b1;
            // y grows downward
            if (pressed[1] && !pressed[2])
                play.player_y <= play.player_y + 1'b1;
            else if (pressed[2] && !pressed[1])
                play.player_y <= play.player_y - 1'b1;
        end
    end

    assign play.wall_hit = (play.player_x <= game_pkg::X_MIN) ||
                           (play.player_x >= game_pkg::X_MAX) ||
                           (play.player_y <= game_pkg::Y_MIN) ||
                           (play.player_y >= game_pkg::Y_MAX);

endmodule

// ==== logic/game_timer.sv ====
// Move tick with selectable speed and fixed score tick, both single-cycle strobes
module game_timer #(
    parameter int unsigned MOVE_PERIOD_SLOW = 1000000,
    parameter int unsigned MOVE_PERIOD_MID  = 750000,
    parameter int unsigned MOVE_PERIOD_FAST = 500000,
    parameter int unsigned SCORE_PERIOD     = 100000000
) (
    input  logic       CLOCK_50,
    input  logic       rst_n,
    input  logic [1:0] speed_sel,
    output logic       move_tick,
    output logic       score_tick
);

    localparam int unsigned MOVE_AB  = (MOVE_PERIOD_SLOW > MOVE_PERIOD_MID) ?
                                       MOVE_PERIOD_SLOW : MOVE_PERIOD_MID;
    localparam int unsigned MOVE_MAX = (MOVE_AB > MOVE_PERIOD_FAST) ? MOVE_AB : MOVE_PERIOD_FAST;
    localparam int unsigned MOVE_W   = $clog2(MOVE_MAX + 1);
    localparam int unsigned SCORE_W  = $clog2(SCORE_PERIOD + 1);

    logic [MOVE_W-1:0]  move_cnt;
    logic [MOVE_W-1:0]  move_reload;
    logic [SCORE_W-1:0] score_cnt;

    // Either switch alone gives the middle speed
    always_comb
    begin
        case (speed_sel)
            2'b00:   move_reload = MOVE_W'(MOVE_PERIOD_SLOW - 1);
            2'b11:   move_reload = MOVE_W'(MOVE_PERIOD_FAST - 1);
            default: move_reload = MOVE_W'(MOVE_PERIOD_MID - 1);
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            move_cnt   <= MOVE_W'(MOVE_PERIOD_SLOW - 1);
            score_cnt  <= SCORE_W'(SCORE_PERIOD - 1);
            move_tick  <= 1'b0;
            score_tick <= 1'b0;
        end
        else
        begin
            move_tick  <= (move_cnt == '0);
            score_tick <= (score_cnt == '0);
            // Speed is sampled only at the wrap
            if (move_cnt == '0)
                move_cnt <= move_reload;
            else
                move_cnt <= move_cnt - 1'b1;
            if (score_cnt == '0)
                score_cnt <= SCORE_W'(SCORE_PERIOD - 1);
            else
                score_cnt <= score_cnt - 1'b1;
        end
    end

endmodule

// ==== logic/play_if.sv ====
// Player position, hit and respawn signals shared by the mover, the swarm and the lives counter
interface play_if;

    game_pkg::coord_x_t player_x;
    game_pkg::coord_y_t player_y;
    logic               wall_hit;
    logic               bee_hit;
    logic               respawn;

    modport mover (output player_x, output player_y, output wall_hit, input respawn);

    modport swarm (input player_x, input player_y, output bee_hit);

    modport keeper (input wall_hit, input bee_hit, output respawn);

endinterface

// ==== logic/display_pkg.sv ====
// Seven-segment digit type, hex glyphs and game-over text used by the display logic
package display_pkg;

    // Active low, bit 6 is segment g and bit 0 is segment a
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_BLANK = 7'h7F;

    localparam seg_t HEX_GLYPH [0:15] = '{
        7'h40, 7'h79, 7'h24, 7'h30,
        7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03,
        7'h46, 7'h21, 7'h06, 7'h0E
    };

    // Indexed by digit number, so the literal reads HEX7 first
    localparam seg_t OVER_TEXT [7:0] = '{
        7'b1000010, // G
        7'b0001000, // A
        7'b1101010, // M
        7'b0000110, // E
        7'b1000000, // O
        7'b1000001, // V
        7'b0000110, // E
        7'b0101111  // r
    };

endpackage

// ==== logic/game_pkg.sv ====
// Game geometry, coordinate, lives and score types and bee start table shared by the game modules
package game_pkg;

    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;
    typedef logic [1:0] lives_t;
    typedef logic [7:0] score_t;

    // Play field walls
    localparam coord_x_t X_MIN = 8'd4;
    localparam coord_x_t X_MAX = 8'd152;
    localparam coord_y_t Y_MIN = 7'd24;
    localparam coord_y_t Y_MAX = 7'd112;

    // Respawn point
    localparam coord_x_t HOME_X = 8'd80;
    localparam coord_y_t HOME_Y = 7'd60;

    // Touch distance per axis
    localparam logic [1:0] HIT_RADIUS = 2'd3;

    localparam lives_t LIVES_FULL = 2'd3;

    // Sign bits, set means the bee moves toward lower coordinates
    typedef struct packed {
        logic x_neg;
        logic y_neg;
    } bee_dir_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        bee_dir_t dir;
    } bee_start_t;

    localparam int MAX_BEES = 6;

    // Fields in order x, y, x_neg, y_neg
    localparam bee_start_t BEE_START [0:MAX_BEES-1] = '{
        {8'd50,  7'd30,  1'b0, 1'b0},
        {8'd34,  7'd74,  1'b1, 1'b0},
        {8'd103, 7'd89,  1'b0, 1'b1},
        {8'd67,  7'd100, 1'b0, 1'b0},
        {8'd108, 7'd56,  1'b0, 1'b0},
        {8'd67,  7'd29,  1'b1, 1'b0}
    };

endpackage
